//--- src/ky11_cfg.svh
`ifndef KY11_CFG_SVH
`define KY11_CFG_SVH

// unibus word address of the switch/light register
`define KY_SWR_ADDR 18'o777570

// identification word, 'KY' in the upper half
`define KY_ID_WORD 32'h4B592015

// npg must stay low this many cycles plus one
`define KY_GRANT_DEBOUNCE 4

// address to msyn wait, about 150ns at 100MHz
`define KY_MSYN_SETUP 15

// wait after ssyn arrives and again after msyn drops
`define KY_DESKEW 8

// give up on ssyn after this many cycles, about 10us
`define KY_SSYN_TIMEOUT 1000

// shared delay counter, must hold the timeout value
`define KY_DELAY_W 10

`define KY_ADDR_W 18
`define KY_DATA_W 16

`endif

//--- src/ky11_bus_pkg.sv
`include "ky11_cfg.svh"

package ky11_bus_pkg;

    // unibus c1:c0 cycle codes, c1 set means the master writes
    typedef enum logic [1:0] {
        DATI  = 2'd0,
        DATIP = 2'd1,
        DATO  = 2'd2,
        DATOB = 2'd3
    } bus_cycle_e;

    // bus lines as seen by the unit
    // syn_* are synchronized, del_* are also delayed for deskew
    typedef struct packed {
        logic [`KY_ADDR_W-1:0] a;
        bus_cycle_e            c;
        logic [`KY_DATA_W-1:0] d;
        logic                  pa;
        logic                  pb;
        logic                  bbsy;
        logic                  npg_l;
        logic                  syn_msyn;
        logic                  syn_ssyn;
        logic                  del_msyn;
        logic                  del_ssyn;
        logic                  init;
    } unibus_in_t;

    // bus lines driven by the unit, all active high except npg_l
    typedef struct packed {
        logic [`KY_ADDR_W-1:0] a;
        bus_cycle_e            c;
        logic [`KY_DATA_W-1:0] d;
        logic                  bbsy;
        logic                  msyn;
        logic                  ssyn;
        logic                  npr;
        logic                  sack;
        logic                  npg_l;
    } unibus_out_t;

    // DATO and DATOB both carry data from master to slave
    function automatic logic is_write(input bus_cycle_e c);
        return c[1];
    endfunction

endpackage

//--- src/ky11_host_pkg.sv
`include "ky11_cfg.svh"

package ky11_host_pkg;

    import ky11_bus_pkg::*;

    // host word addresses, 5..7 are unmapped
    typedef enum logic [2:0] {
        REG_ID   = 3'd0,
        REG_SWR  = 3'd1,
        REG_CTRL = 3'd2,
        REG_DMA  = 3'd3,
        REG_DATA = 3'd4
    } host_reg_e;

    // dma request from the register file
    // addr, cycle and wdata stay stable while the engine is busy
    typedef struct packed {
        logic [`KY_ADDR_W-1:0] addr;
        bus_cycle_e            cycle;
        logic [`KY_DATA_W-1:0] wdata;
        logic                  start;
    } dma_cmd_t;

    // engine state reported back to the host
    typedef struct packed {
        logic                  busy;
        logic                  timo;
        logic                  perr;
        logic [`KY_DATA_W-1:0] rdata;
    } dma_status_t;

endpackage

//--- src/ky11_host_regs.sv
`timescale 1ns/1ns
`include "ky11_cfg.svh"

module ky11_host_regs import ky11_bus_pkg::*, ky11_host_pkg::*; (
    input  logic                  CLOCK,
    input  logic                  rst_n,
    input  logic                  init,
    input  logic                  arm_write,
    input  host_reg_e             arm_waddr,
    input  logic [31:0]           arm_wdata,
    input  host_reg_e             arm_raddr,
    input  logic [`KY_DATA_W-1:0] lights,
    input  dma_status_t           dma_status,
    output logic [31:0]           arm_rdata,
    output logic [`KY_DATA_W-1:0] switches,
    output logic                  enable,
    output dma_cmd_t              dma_cmd
);

    logic [`KY_ADDR_W-1:0] dma_addr;
    bus_cycle_e            dma_cycle;
    logic [`KY_DATA_W-1:0] dma_data;
    logic                  start;
    logic                  busy_q;
    logic                  engaged;

    // the start pulse counts as busy, the engine sees it one edge later
    assign engaged = dma_status.busy | start;

    always_ff @(posedge CLOCK or negedge rst_n) begin
        if (!rst_n) begin
            switches <= '0;
            enable   <= 1'b0;
            start    <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            // start is a single cycle pulse
            start  <= 1'b0;
            busy_q <= dma_status.busy;
            if (arm_write) begin
                case (arm_waddr)
                    REG_SWR:  switches <= arm_wdata[15:0];
                    REG_CTRL: enable <= arm_wdata[31];
                    // bit 29 kicks off a cycle, never during bus init
                    REG_DMA:  if (!engaged) start <= arm_wdata[29] & ~init;
                    default:  ;
                endcase
            end
        end
    end

    // dma address, cycle and data
    always_ff @(posedge CLOCK) begin
        // end of cycle, pick up read data (write data comes back unchanged)
        if (busy_q && !dma_status.busy) begin
            dma_data <= dma_status.rdata;
        end
        if (arm_write && !engaged) begin
            case (arm_waddr)
                REG_DMA: begin
                    dma_addr  <= arm_wdata[17:0];
                    dma_cycle <= bus_cycle_e'(arm_wdata[27:26]);
                end
                REG_DATA: dma_data <= arm_wdata[15:0];
                default:  ;
            endcase
        end
    end

    assign dma_cmd = '{addr: dma_addr, cycle: dma_cycle, wdata: dma_data, start: start};

    // read mux, purely combinational from arm_raddr
    always_comb begin
        case (arm_raddr)
            REG_ID:   arm_rdata = `KY_ID_WORD;
            // lights read-only in the upper half
            REG_SWR:  arm_rdata = {lights, switches};
            REG_CTRL: arm_rdata = {enable, 31'b0};
            // busy in 31:29 reads as 1 while active
            REG_DMA:  arm_rdata = {2'b00, engaged, dma_status.timo, dma_cycle,
                                   dma_status.perr, 7'b0, dma_addr};
            REG_DATA: arm_rdata = {16'b0, dma_data};
            default:  arm_rdata = 32'hDEADBEEF;
        endcase
    end

    // host never restarts an engine that is still running a cycle
    a_no_start_busy: assert property (@(posedge CLOCK) disable iff (!rst_n)
        dma_cmd.start |-> !dma_status.busy)
        else $error("start pulsed while dma engine busy");

endmodule

//--- src/ky11_swr_slave.sv
`timescale 1ns/1ns
`include "ky11_cfg.svh"

module ky11_swr_slave import ky11_bus_pkg::*; (
    input  logic                  CLOCK,
    input  logic                  rst_n,
    input  unibus_in_t            bus_in,
    input  logic                  enable,
    input  logic [`KY_DATA_W-1:0] switches,
    output logic [`KY_DATA_W-1:0] lights,
    output logic                  ssyn,
    output logic [`KY_DATA_W-1:0] swr_data
);

    logic hit;

    // word address match, byte bit ignored
    assign hit = enable && ({bus_in.a[`KY_ADDR_W-1:1], 1'b0} == `KY_SWR_ADDR);

    always_ff @(posedge CLOCK or negedge rst_n) begin
        if (!rst_n) begin
            lights   <= '0;
            ssyn     <= 1'b0;
            swr_data <= '0;
        end else if (bus_in.init) begin
            ssyn     <= 1'b0;
            swr_data <= '0;
        end else if (!bus_in.del_msyn) begin
            // master finished, let go of the bus
            ssyn     <= 1'b0;
            swr_data <= '0;
        end else if (hit && !ssyn) begin
            ssyn <= 1'b1;
            if (is_write(bus_in.c)) begin
                // DATOB writes one byte, a0 picks the high byte
                if (bus_in.c != DATOB || bus_in.a[0]) begin
                    lights[15:8] <= bus_in.d[15:8];
                end
                if (bus_in.c != DATOB || !bus_in.a[0]) begin
                    lights[7:0] <= bus_in.d[7:0];
                end
            end else begin
                swr_data <= switches;
            end
        end
    end

    // a disabled register never answers the bus
    a_ssyn_enabled: assert property (@(posedge CLOCK) disable iff (!rst_n)
        $rose(ssyn) |-> $past(enable))
        else $error("ssyn rose with enable low");

endmodule

//--- src/ky11_dma_master.sv
`timescale 1ns/1ns
`include "ky11_cfg.svh"

module ky11_dma_master import ky11_bus_pkg::*, ky11_host_pkg::*; (
    input  logic        CLOCK,
    input  logic        rst_n,
    input  logic        turbo,
    input  unibus_in_t  bus_in,
    input  dma_cmd_t    dma_cmd,
    output dma_status_t dma_status,
    output unibus_out_t bus_out
);

    localparam logic [`KY_DELAY_W-1:0] GRANT_CNT = `KY_DELAY_W'(`KY_GRANT_DEBOUNCE);
    localparam logic [`KY_DELAY_W-1:0] SETUP_CNT = `KY_DELAY_W'(`KY_MSYN_SETUP);
    localparam logic [`KY_DELAY_W-1:0] DESKW_CNT = `KY_DELAY_W'(`KY_DESKEW);
    localparam logic [`KY_DELAY_W-1:0] TIMO_CNT  = `KY_DELAY_W'(`KY_SSYN_TIMEOUT);

    typedef enum logic [2:0] {
        IDLE,
        ARBITRATE,
        BUS_WAIT,
        ADDR_SETUP,
        WAIT_SSYN,
        READ_DESKEW,
        RELEASE
    } dma_state_e;

    dma_state_e            state;
    logic [`KY_DELAY_W-1:0] dly;
    logic [`KY_ADDR_W-1:0] a_q;
    bus_cycle_e            c_q;
    logic [`KY_DATA_W-1:0] d_q;
    logic                  bbsy_q;
    logic                  msyn_q;
    logic                  npr_q;
    logic                  sack_q;
    logic                  timo_q;
    logic                  perr_q;
    logic [`KY_DATA_W-1:0] rdata_q;

    always_ff @(posedge CLOCK or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            dly    <= '0;
            a_q    <= '0;
            c_q    <= DATI;
            d_q    <= '0;
            bbsy_q <= 1'b0;
            msyn_q <= 1'b0;
            npr_q  <= 1'b0;
            sack_q <= 1'b0;
            timo_q <= 1'b0;
            perr_q <= 1'b0;
        end else if (bus_in.init) begin
            // bus init aborts whatever is in flight, timo stays as is
            state  <= IDLE;
            dly    <= '0;
            a_q    <= '0;
            c_q    <= DATI;
            d_q    <= '0;
            bbsy_q <= 1'b0;
            msyn_q <= 1'b0;
            npr_q  <= 1'b0;
            sack_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    dly <= '0;
                    if (dma_cmd.start) begin
                        // timo stays set unless the cycle ends cleanly
                        timo_q <= 1'b1;
                        perr_q <= 1'b0;
                        state  <= ARBITRATE;
                    end
                end
                // raise npr, then want npg low for GRANT_CNT+1 cycles in a row
                ARBITRATE: begin
                    if (!npr_q) begin
                        npr_q <= 1'b1;
                        dly   <= '0;
                    end else if (bus_in.npg_l) begin
                        dly <= '0;
                    end else if (dly != GRANT_CNT) begin
                        dly <= dly + 1'b1;
                    end else begin
                        sack_q <= 1'b1;
                        state  <= BUS_WAIT;
                    end
                end
                // previous master must be completely off the bus
                BUS_WAIT: begin
                    if (!bus_in.bbsy && !bus_in.syn_msyn && !bus_in.syn_ssyn) begin
                        a_q    <= dma_cmd.addr;
                        c_q    <= dma_cmd.cycle;
                        d_q    <= is_write(dma_cmd.cycle) ? dma_cmd.wdata : '0;
                        bbsy_q <= 1'b1;
                        npr_q  <= 1'b0;
                        dly    <= '0;
                        state  <= ADDR_SETUP;
                    end
                end
                ADDR_SETUP: begin
                    sack_q <= 1'b0;
                    if (dly != SETUP_CNT && !turbo) begin
                        dly <= dly + 1'b1;
                    end else begin
                        msyn_q <= 1'b1;
                        dly    <= '0;
                        state  <= WAIT_SSYN;
                    end
                end
                WAIT_SSYN: begin
                    if (bus_in.del_ssyn) begin
                        dly   <= '0;
                        state <= READ_DESKEW;
                    end else if (dly != TIMO_CNT) begin
                        dly <= dly + 1'b1;
                    end else begin
                        // nobody answered, release everything
                        a_q    <= '0;
                        c_q    <= DATI;
                        d_q    <= '0;
                        bbsy_q <= 1'b0;
                        msyn_q <= 1'b0;
                        state  <= IDLE;
                    end
                end
                READ_DESKEW: begin
                    if (dly != DESKW_CNT && !turbo) begin
                        dly <= dly + 1'b1;
                    end else begin
                        // KD11-E parity rule: pa low with pb high
                        if (!is_write(c_q)) begin
                            perr_q <= ~bus_in.pa & bus_in.pb;
                        end
                        msyn_q <= 1'b0;
                        dly    <= '0;
                        state  <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (dly != DESKW_CNT && !turbo) begin
                        dly <= dly + 1'b1;
                    end else if (!bus_in.del_ssyn) begin
                        a_q    <= '0;
                        c_q    <= DATI;
                        d_q    <= '0;
                        bbsy_q <= 1'b0;
                        timo_q <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // data register, preloaded with write data so a write or timeout returns it unchanged
    always_ff @(posedge CLOCK) begin
        if (state == IDLE && dma_cmd.start) begin
            rdata_q <= dma_cmd.wdata;
        end else if (state == READ_DESKEW && (dly == DESKW_CNT || turbo) && !is_write(c_q)) begin
            rdata_q <= bus_in.d;
        end
    end

    assign dma_status = '{busy: state != IDLE, timo: timo_q, perr: perr_q, rdata: rdata_q};

    // slave side lines belong to the top
    assign bus_out = '{a: a_q, c: c_q, d: d_q, bbsy: bbsy_q, msyn: msyn_q,
                       ssyn: 1'b0, npr: npr_q, sack: sack_q, npg_l: 1'b0};

    a_msyn_bbsy: assert property (@(posedge CLOCK) disable iff (!rst_n)
        msyn_q |-> bbsy_q)
        else $error("msyn asserted without bbsy");

    // npr has to be gone once we are bus master
    a_npr_bbsy: assert property (@(posedge CLOCK) disable iff (!rst_n)
        bbsy_q |-> !npr_q)
        else $error("npr still high while holding bbsy");

endmodule

//--- src/ky11_top.sv
`timescale 1ns/1ns

module ky11_top import ky11_bus_pkg::*, ky11_host_pkg::*; (
    input  logic        CLOCK,
    input  logic        rst_n,
    input  logic        turbo,
    input  logic        arm_write,
    input  logic [2:0]  arm_waddr,
    input  logic [31:0] arm_wdata,
    input  logic [2:0]  arm_raddr,
    output logic [31:0] arm_rdata,
    input  unibus_in_t  bus_in,
    output unibus_out_t bus_out
);

    logic [15:0] switches;
    logic [15:0] lights;
    logic [15:0] swr_data;
    logic        enable;
    logic        swr_ssyn;
    dma_cmd_t    dma_cmd;
    dma_status_t dma_status;
    unibus_out_t mst_out;

    ky11_host_regs u_regs (
        .CLOCK      (CLOCK),
        .rst_n      (rst_n),
        .init       (bus_in.init),
        .arm_write  (arm_write),
        .arm_waddr  (host_reg_e'(arm_waddr)),
        .arm_wdata  (arm_wdata),
        .arm_raddr  (host_reg_e'(arm_raddr)),
        .lights     (lights),
        .dma_status (dma_status),
        .arm_rdata  (arm_rdata),
        .switches   (switches),
        .enable     (enable),
        .dma_cmd    (dma_cmd)
    );

    ky11_swr_slave u_swr (
        .CLOCK    (CLOCK),
        .rst_n    (rst_n),
        .bus_in   (bus_in),
        .enable   (enable),
        .switches (switches),
        .lights   (lights),
        .ssyn     (swr_ssyn),
        .swr_data (swr_data)
    );

    ky11_dma_master u_dma (
        .CLOCK      (CLOCK),
        .rst_n      (rst_n),
        .turbo      (turbo),
        .bus_in     (bus_in),
        .dma_cmd    (dma_cmd),
        .dma_status (dma_status),
        .bus_out    (mst_out)
    );

    // both data drivers idle at zero, so OR them onto the bus
    // npg is blocked while our own npr is up
    always_comb begin
        bus_out       = mst_out;
        bus_out.d     = mst_out.d | swr_data;
        bus_out.ssyn  = swr_ssyn;
        bus_out.npg_l = mst_out.npr ? 1'b1 : bus_in.npg_l;
    end

endmodule

//--- tests/tb_ky11.sv
`timescale 1ns/1ns
`include "ky11_cfg.svh"

module tb_ky11 import ky11_bus_pkg::*, ky11_host_pkg::*; ();

    logic        CLOCK = 1'b0;
    logic        rst_n;
    logic        turbo;
    logic        arm_write;
    logic [2:0]  arm_waddr;
    logic [31:0] arm_wdata;
    logic [2:0]  arm_raddr;
    logic [31:0] arm_rdata;
    unibus_in_t  bus_in;
    unibus_out_t bus_out;

    logic [31:0] seed;
    int          errors;
    int          timeouts;
    logic [15:0] sw_model;
    logic [15:0] lights_model;
    // sparse memory behind the dma master keyed by word address
    logic [15:0] mem [logic [17:0]];

    ky11_top dut0 (
        .CLOCK     (CLOCK),
        .rst_n     (rst_n),
        .turbo     (turbo),
        .arm_write (arm_write),
        .arm_waddr (arm_waddr),
        .arm_wdata (arm_wdata),
        .arm_raddr (arm_raddr),
        .arm_rdata (arm_rdata),
        .bus_in    (bus_in),
        .bus_out   (bus_out)
    );

    // 50 MHz
    always #10 CLOCK = ~CLOCK;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] r);
        seed = xorshift(seed);
        r = seed;
    endtask

    // fill pattern for untouched memory words uses every address bit
    function automatic logic [15:0] fill_word(input logic [17:0] addr);
        return addr[15:0] ^ {addr[17:16], addr[17:4]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] mem_read(input logic [17:0] key);
        if (mem.exists(key)) begin
            return mem[key];
        end
        return fill_word(key);
    endfunction

    // DATOB with a0 set lands in the high byte
    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] data,
                                                input bus_cycle_e cyc,
                                                input logic a0);
        logic [15:0] r;
        r = data;
        if (cyc == DATOB) begin
            r = a0 ? {data[15:8], old[7:0]} : {old[15:8], data[7:0]};
        end
        return r;
    endfunction

    task automatic flag_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic flag_timeout(input string what);
        timeouts++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    // host write lands on the edge where arm_write is high
    task automatic write_reg(input host_reg_e addr, input logic [31:0] data);
        @(posedge CLOCK);
        arm_write <= 1'b1;
        arm_waddr <= addr;
        arm_wdata <= data;
        @(posedge CLOCK);
        arm_write <= 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
        @(posedge CLOCK);
        arm_raddr <= addr;
        @(negedge CLOCK);
        data = arm_rdata;
    endtask

    // testbench as unibus master talking to the switch register
    task automatic drive_bus_cycle(input bus_cycle_e cyc, input logic [17:0] addr,
                                   input logic [15:0] data, input logic expect_ack,
                                   output logic [15:0] rdata);
        logic acked;
        int   n;
        acked = 1'b0;
        rdata = 16'h0;
        @(posedge CLOCK);
        bus_in.a <= addr;
        bus_in.c <= cyc;
        bus_in.d <= cyc[1] ? data : 16'h0;
        // one cycle of address setup before msyn
        @(posedge CLOCK);
        bus_in.syn_msyn <= 1'b1;
        bus_in.del_msyn <= 1'b1;
        for (n = 0; n < 40 && !acked; n++) begin
            @(negedge CLOCK);
            acked = bus_out.ssyn;
        end
        if (acked) begin
            rdata = bus_out.d;
        end
        if (expect_ack && !acked) begin
            flag_timeout("ssyn from the switch register");
        end
        if (!expect_ack && acked) begin
            errors++;
            $display("switch register answered at %0t although enable was clear", $time);
        end
        @(posedge CLOCK);
        bus_in.syn_msyn <= 1'b0;
        bus_in.del_msyn <= 1'b0;
        bus_in.a        <= '0;
        bus_in.c        <= DATI;
        bus_in.d        <= '0;
        for (n = 0; n < 10 && acked; n++) begin
            @(negedge CLOCK);
            acked = bus_out.ssyn;
        end
        if (acked) begin
            flag_timeout("ssyn to drop");
        end
    endtask

    // one host-started dma cycle where the testbench grants npg and plays memory
    task automatic dma_transfer(input bus_cycle_e cyc, input logic [17:0] addr,
                                input logic [15:0] wdata, input logic answer);
        logic [31:0] r;
        logic [31:0] rd;
        logic [31:0] exp;
        logic [17:0] key;
        logic [15:0] word;
        logic [15:0] bus_d;
        logic        seen;
        logic        exp_perr;
        int          n;
        key      = {addr[17:1], 1'b0};
        exp_perr = 1'b0;
        word     = 16'h0;
        bus_d    = 16'h0;
        next_random(r);
        @(posedge CLOCK);
        turbo <= (r[2:0] == 3'd0);
        if (cyc[1]) begin
            write_reg(REG_DATA, {16'h0, wdata});
        end
        write_reg(REG_DMA, {2'b00, 1'b1, 1'b0, cyc, 1'b0, 7'h0, addr});

        seen = 1'b0;
        for (n = 0; n < 10 && !seen; n++) begin
            @(negedge CLOCK);
            seen = bus_out.npr;
        end
        if (!seen) begin
            flag_timeout("npr");
        end

        @(posedge CLOCK);
        bus_in.npg_l <= 1'b0;
        // our own npr blocks the grant towards the next device
        @(negedge CLOCK);
        if (bus_out.npg_l !== 1'b1) begin
            flag_mismatch("bus_out.npg_l", 64'(bus_out.npg_l), 64'h1);
        end
        if (r[4]) begin
            // short dropout restarts the debounce count
            repeat (2) @(posedge CLOCK);
            bus_in.npg_l <= 1'b1;
            @(posedge CLOCK);
            bus_in.npg_l <= 1'b0;
        end
        seen = 1'b0;
        for (n = 0; n < 30 && !seen; n++) begin
            @(negedge CLOCK);
            seen = bus_out.sack;
        end
        if (!seen) begin
            flag_timeout("sack");
        end
        @(posedge CLOCK);
        bus_in.npg_l <= 1'b1;

        seen = 1'b0;
        for (n = 0; n < 100 && !seen; n++) begin
            @(negedge CLOCK);
            seen = bus_out.msyn;
        end
        if (!seen) begin
            flag_timeout("msyn from the dma master");
        end
        // bus lines as the slave sees them when msyn rises
        word  = cyc[1] ? wdata : 16'h0;
        bus_d = bus_out.d;
        if (bus_out.a !== addr) begin
            flag_mismatch("bus_out.a", 64'(bus_out.a), 64'(addr));
        end
        if (bus_out.c !== cyc) begin
            flag_mismatch("bus_out.c", 64'(bus_out.c), 64'(cyc));
        end
        if (bus_out.d !== word) begin
            flag_mismatch("bus_out.d", 64'(bus_out.d), 64'(word));
        end
        if (bus_out.bbsy !== 1'b1) begin
            flag_mismatch("bus_out.bbsy", 64'(bus_out.bbsy), 64'h1);
        end
        if (bus_out.npr !== 1'b0) begin
            flag_mismatch("bus_out.npr", 64'(bus_out.npr), 64'h0);
        end

        if (answer) begin
            repeat (r[7:5]) @(posedge CLOCK);
            @(posedge CLOCK);
            if (cyc[1]) begin
                mem[key] = merge_bytes(mem_read(key), bus_d, cyc, addr[0]);
            end else begin
                bus_in.d  <= mem_read(key);
                bus_in.pa <= r[8];
                bus_in.pb <= r[9];
                exp_perr = !r[8] && r[9];
            end
            bus_in.syn_ssyn <= 1'b1;
            bus_in.del_ssyn <= 1'b1;
            seen = 1'b0;
            for (n = 0; n < 100 && !seen; n++) begin
                @(negedge CLOCK);
                seen = !bus_out.msyn;
            end
            if (!seen) begin
                flag_timeout("msyn to drop");
            end
            @(posedge CLOCK);
            bus_in.syn_ssyn <= 1'b0;
            bus_in.del_ssyn <= 1'b0;
            bus_in.d        <= '0;
            bus_in.pa       <= 1'b0;
            bus_in.pb       <= 1'b0;
        end

        // host polls busy since a silent slave needs the whole ssyn timeout
        seen = 1'b0;
        rd   = 32'h0;
        for (n = 0; n < 1500 && !seen; n++) begin
            read_reg(REG_DMA, rd);
            seen = !rd[29];
        end
        if (!seen) begin
            flag_timeout("dma busy to clear");
        end
        exp = {3'b000, !answer, cyc, exp_perr, 7'h0, addr};
        if (rd !== exp) begin
            flag_mismatch("REG_DMA", 64'(rd), 64'(exp));
        end
        if (!answer) begin
            if ({bus_out.bbsy, bus_out.msyn} !== 2'b00) begin
                flag_mismatch("bus_out.bbsy/msyn", 64'({bus_out.bbsy, bus_out.msyn}), 64'h0);
            end
            if ({bus_out.a, bus_out.d} !== 34'h0) begin
                flag_mismatch("bus_out.a/d", 64'({bus_out.a, bus_out.d}), 64'h0);
            end
        end else if (!cyc[1]) begin
            read_reg(REG_DATA, rd);
            exp = {16'h0, mem_read(key)};
            if (rd !== exp) begin
                flag_mismatch("REG_DATA", 64'(rd), 64'(exp));
            end
        end
    endtask

    initial begin : main
        logic [31:0] r;
        logic [31:0] rd;
        logic [15:0] d16;
        bus_cycle_e  cyc;
        int          i;
        errors       = 0;
        timeouts     = 0;
        seed         = 32'h3920a115;
        sw_model     = 16'h0;
        lights_model = 16'h0;
        rst_n        = 1'b0;
        turbo        = 1'b0;
        arm_write    = 1'b0;
        arm_waddr    = 3'd0;
        arm_wdata    = 32'h0;
        arm_raddr    = 3'd0;
        bus_in       = '0;
        bus_in.npg_l = 1'b1;
        repeat (8) @(posedge CLOCK);
        rst_n <= 1'b1;

        // quiet bus after reset with npg passing straight through
        @(negedge CLOCK);
        if (bus_out !== 42'h1) begin
            flag_mismatch("bus_out", 64'(bus_out), 64'h1);
        end
        @(posedge CLOCK);
        bus_in.npg_l <= 1'b0;
        @(negedge CLOCK);
        if (bus_out.npg_l !== 1'b0) begin
            flag_mismatch("bus_out.npg_l", 64'(bus_out.npg_l), 64'h0);
        end
        @(posedge CLOCK);
        bus_in.npg_l <= 1'b1;

        // id word and unmapped addresses
        read_reg(REG_ID, rd);
        if (rd !== 32'h4B592015) begin
            flag_mismatch("REG_ID", 64'(rd), 64'h4B592015);
        end
        for (i = 5; i < 8; i++) begin
            read_reg(3'(i), rd);
            if (rd !== 32'hDEADBEEF) begin
                flag_mismatch("arm_rdata unmapped", 64'(rd), 64'hDEADBEEF);
            end
        end

        // switches via host and then DATI from the bus
        write_reg(REG_CTRL, 32'h8000_0000);
        for (i = 0; i < 4; i++) begin
            next_random(r);
            sw_model = r[15:0];
            write_reg(REG_SWR, r);
            read_reg(REG_SWR, rd);
            if (rd[15:0] !== sw_model) begin
                flag_mismatch("REG_SWR switches", 64'(rd[15:0]), 64'(sw_model));
            end
            drive_bus_cycle(DATI, `KY_SWR_ADDR, 16'h0, 1'b1, d16);
            if (d16 !== sw_model) begin
                flag_mismatch("bus_out.d", 64'(d16), 64'(sw_model));
            end
        end
        write_reg(REG_CTRL, 32'h0);
        drive_bus_cycle(DATI, `KY_SWR_ADDR, 16'h0, 1'b0, d16);
        write_reg(REG_CTRL, 32'h8000_0000);

        // lights by word and by byte
        for (i = 0; i < 8; i++) begin
            next_random(r);
            cyc = r[16] ? DATOB : DATO;
            drive_bus_cycle(cyc, `KY_SWR_ADDR | 18'(r[17]), r[15:0], 1'b1, d16);
            lights_model = merge_bytes(lights_model, r[15:0], cyc, r[17]);
            read_reg(REG_SWR, rd);
            if (rd[31:16] !== lights_model) begin
                flag_mismatch("REG_SWR lights", 64'(rd[31:16]), 64'(lights_model));
            end
        end

        // dma reads and writes and one with no slave
        for (i = 0; i < 4; i++) begin
            next_random(r);
            cyc = r[20] ? DATIP : DATI;
            dma_transfer(cyc, r[17:0], 16'h0, 1'b1);
        end
        for (i = 0; i < 4; i++) begin
            next_random(r);
            cyc = r[20] ? DATOB : DATO;
            dma_transfer(cyc, r[17:0], r[31:16], 1'b1);
        end
        next_random(r);
        dma_transfer(DATO, r[17:0], r[31:16], 1'b0);

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/ky11_bus_pkg.sv
src/ky11_host_pkg.sv
src/ky11_host_regs.sv
src/ky11_swr_slave.sv
src/ky11_dma_master.sv
src/ky11_top.sv
tests/tb_ky11.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = tb_ky11
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
